// ==== all.f ====
+incdir+include
src/isa_pkg.sv
src/ctrl_pkg.sv
src/stack_alu.sv
src/core_datapath.sv
src/core_control.sv
src/lisp_core.sv
verif/tb_mem_model.sv
verif/core_tb.sv

// ==== include/core_config.svh ====
// Core configuration macros: word, opcode and instruction widths, data memory size
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// Data word and address width
`define CORE_WORD_W 16

// Opcode field width
`define CORE_OPCODE_W 5

// Instruction word is the opcode above a one-word parameter
`define CORE_INSTR_W 21

// Number of data memory words
// Stack and base pointers reset just below the top of this space
`define CORE_DMEM_SIZE 8192

`endif

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module core_tb -f all.f -o core_tb_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "Verilator build failed, see build.log"
	exit 1
fi

./obj_dir/core_tb_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
	cat sim.log
	echo "Simulation exited with an error status"
	exit 1
fi

cat sim.log

if grep -q "Regression failed" sim.log; then
	exit 1
fi

exit 0

// ==== src/core_control.sv ====
// Core control: instruction sequencer producing per-cycle datapath selects and write enable
`default_nettype none

module core_control (
	input  logic               clk,
	input  logic               rst_n,
	input  isa_pkg::opcode_e   opcode,
	input  isa_pkg::word_t     param,
	input  isa_pkg::word_t     top_of_stack,
	output ctrl_pkg::sp_sel_e  sp_sel,
	output ctrl_pkg::op0_sel_e op0_sel,
	output ctrl_pkg::op1_sel_e op1_sel,
	output ctrl_pkg::tos_sel_e tos_sel,
	output ctrl_pkg::ma_sel_e  ma_sel,
	output ctrl_pkg::mw_sel_e  mw_sel,
	output ctrl_pkg::bp_sel_e  bp_sel,
	output ctrl_pkg::ip_sel_e  ip_sel,
	output isa_pkg::opcode_e   alu_op,
	output logic               data_mem_write_enable
);

	import isa_pkg::*;
	import ctrl_pkg::*;

	state_e state;
	state_e state_next;

	always_comb
	begin
		state_next = state;
		data_mem_write_enable = 1'b0;
		ma_sel = MA_STACK_POINTER;
		mw_sel = MW_BASE_POINTER;
		sp_sel = SP_CURRENT;
		tos_sel = TOS_CURRENT;
		bp_sel = BP_CURRENT;
		ip_sel = IP_CURRENT;
		op0_sel = OP0_TOP_OF_STACK;
		op1_sel = OP1_MEM_READ;
		alu_op = opcode;

		if (rst_n)
		begin
			case (state)
				ST_DECODE:
				begin
					case (opcode)
						// Push old base pointer, jump to TOS, keep return address in TOS
						OP_CALL:
						begin
							ip_sel = IP_STACK_TARGET;
							sp_sel = SP_DECREMENT;
							ma_sel = MA_ALU;
							op0_sel = OP0_STACK_POINTER;
							op1_sel = OP1_ONE;
							alu_op = OP_SUB;
							data_mem_write_enable = 1'b1;
							mw_sel = MW_BASE_POINTER;
							bp_sel = BP_ALU;
							tos_sel = TOS_RETURN_ADDR;
						end

						// Saved return address lives just below the base pointer
						OP_RETURN:
						begin
							ma_sel = MA_ALU;
							op0_sel = OP0_BASE_POINTER;
							op1_sel = OP1_ONE;
							alu_op = OP_SUB;
							state_next = ST_RETURN2;
						end

						OP_POP:
						begin
							sp_sel = SP_INCREMENT;
							state_next = ST_PUSH_MEM_RESULT;
						end

						OP_LOAD:
						begin
							ma_sel = MA_TOP_OF_STACK;
							state_next = ST_PUSH_MEM_RESULT;
						end

						// Fetch the value under the address first
						OP_STORE:
						begin
							state_next = ST_GOT_STORE_VALUE;
						end

						OP_ADD, OP_SUB, OP_GTR, OP_GTE, OP_EQ, OP_NEQ,
						OP_AND, OP_OR, OP_XOR, OP_LSHIFT, OP_RSHIFT:
						begin
							state_next = ST_GOT_NOS;
						end

						// Spill TOS below the stack pointer and load a new TOS
						OP_PUSH, OP_DUP, OP_GETBP:
						begin
							sp_sel = SP_DECREMENT;
							ma_sel = MA_ALU;
							op0_sel = OP0_STACK_POINTER;
							op1_sel = OP1_ONE;
							alu_op = OP_SUB;
							data_mem_write_enable = 1'b1;
							mw_sel = MW_TOP_OF_STACK;
							if (opcode == OP_PUSH)
								tos_sel = TOS_PARAM;
							else if (opcode == OP_GETBP)
								tos_sel = TOS_BASE_POINTER;
							ip_sel = IP_NEXT;
						end

						OP_RESERVE:
						begin
							// Zero locals leaves the stack alone
							if (param != '0)
							begin
								ma_sel = MA_STACK_POINTER_MINUS_ONE;
								data_mem_write_enable = 1'b1;
								mw_sel = MW_TOP_OF_STACK;
								sp_sel = SP_ALU;
								op0_sel = OP0_STACK_POINTER;
								op1_sel = OP1_PARAM;
								alu_op = OP_SUB;
							end
							ip_sel = IP_NEXT;
						end

						OP_GOTO:
						begin
							ip_sel = IP_BRANCH_TARGET;
						end

						// Branch on zero TOS, then refill TOS from the stack
						OP_BFALSE:
						begin
							if (top_of_stack == '0)
								ip_sel = IP_BRANCH_TARGET;
							else
								ip_sel = IP_NEXT;
							sp_sel = SP_INCREMENT;
							state_next = ST_BFALSE2;
						end

						OP_GETLOCAL:
						begin
							sp_sel = SP_DECREMENT;
							ma_sel = MA_ALU;
							op0_sel = OP0_STACK_POINTER;
							op1_sel = OP1_ONE;
							alu_op = OP_SUB;
							data_mem_write_enable = 1'b1;
							mw_sel = MW_TOP_OF_STACK;
							state_next = ST_GETLOCAL2;
						end

						OP_SETLOCAL:
						begin
							ma_sel = MA_ALU;
							op0_sel = OP0_BASE_POINTER;
							op1_sel = OP1_PARAM;
							alu_op = OP_ADD;
							data_mem_write_enable = 1'b1;
							mw_sel = MW_TOP_OF_STACK;
							state_next = ST_LOAD_TOS1;
						end

						// Drop arguments but keep TOS, which holds the return value
						OP_CLEANUP:
						begin
							sp_sel = SP_ALU;
							op0_sel = OP0_STACK_POINTER;
							op1_sel = OP1_PARAM;
							alu_op = OP_ADD;
							ip_sel = IP_NEXT;
						end

						default:
						begin
							ip_sel = IP_NEXT;
						end
					endcase
				end

				// Write NOS to the address in TOS, NOS becomes the new TOS
				ST_GOT_STORE_VALUE:
				begin
					data_mem_write_enable = 1'b1;
					ma_sel = MA_TOP_OF_STACK;
					mw_sel = MW_MEM_READ_RESULT;
					tos_sel = TOS_MEMORY_RESULT;
					sp_sel = SP_INCREMENT;
					ip_sel = IP_NEXT;
					state_next = ST_DECODE;
				end

				ST_GOT_NOS:
				begin
					tos_sel = TOS_ALU_RESULT;
					sp_sel = SP_INCREMENT;
					ip_sel = IP_NEXT;
					state_next = ST_DECODE;
				end

				ST_LOAD_TOS1:
				begin
					sp_sel = SP_INCREMENT;
					state_next = ST_PUSH_MEM_RESULT;
				end

				ST_GETLOCAL2:
				begin
					ma_sel = MA_ALU;
					op0_sel = OP0_BASE_POINTER;
					op1_sel = OP1_PARAM;
					alu_op = OP_ADD;
					state_next = ST_PUSH_MEM_RESULT;
				end

				// Pointer already moved in decode
				ST_BFALSE2:
				begin
					tos_sel = TOS_MEMORY_RESULT;
					state_next = ST_DECODE;
				end

				ST_PUSH_MEM_RESULT:
				begin
					tos_sel = TOS_MEMORY_RESULT;
					ip_sel = IP_NEXT;
					state_next = ST_DECODE;
				end

				// Jump to the saved address and fetch the caller's base pointer
				ST_RETURN2:
				begin
					ip_sel = IP_MEM_READ_RESULT;
					ma_sel = MA_BASE_POINTER;
					sp_sel = SP_ALU;
					op0_sel = OP0_BASE_POINTER;
					op1_sel = OP1_ONE;
					alu_op = OP_ADD;
					state_next = ST_RETURN3;
				end

				ST_RETURN3:
				begin
					bp_sel = BP_MEM;
					state_next = ST_DECODE;
				end

				default:
				begin
					state_next = ST_DECODE;
				end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			state <= ST_DECODE;
		else
			state <= state_next;
	end

endmodule

`default_nettype wire

// ==== src/core_datapath.sv ====
// Core datapath: stack, base and instruction pointers, top of stack, memory address and write data
`default_nettype none

`include "core_config.svh"

module core_datapath (
	input  logic               clk,
	input  logic               rst_n,
	input  ctrl_pkg::sp_sel_e  sp_sel,
	input  ctrl_pkg::tos_sel_e tos_sel,
	input  ctrl_pkg::ma_sel_e  ma_sel,
	input  ctrl_pkg::mw_sel_e  mw_sel,
	input  ctrl_pkg::bp_sel_e  bp_sel,
	input  ctrl_pkg::ip_sel_e  ip_sel,
	input  isa_pkg::word_t     param,
	input  isa_pkg::word_t     alu_result,
	input  isa_pkg::word_t     data_mem_read_value,
	output isa_pkg::word_t     top_of_stack,
	output isa_pkg::word_t     stack_pointer,
	output isa_pkg::word_t     base_pointer,
	output isa_pkg::word_t     instr_mem_address,
	output isa_pkg::word_t     data_mem_address,
	output isa_pkg::word_t     data_mem_write_value
);

	import isa_pkg::*;
	import ctrl_pkg::*;

	localparam word_t SP_RESET = word_t'(`CORE_DMEM_SIZE - 8);
	localparam word_t BP_RESET = word_t'(`CORE_DMEM_SIZE - 4);

	word_t instruction_pointer;
	word_t tos_next;
	word_t sp_next;
	word_t bp_next;
	word_t ip_next;

	always_comb
	begin
		case (sp_sel)
			SP_DECREMENT: sp_next = stack_pointer - word_t'(1);
			SP_INCREMENT: sp_next = stack_pointer + word_t'(1);
			SP_ALU:       sp_next = alu_result;
			default:      sp_next = stack_pointer;
		endcase
	end

	always_comb
	begin
		case (tos_sel)
			// Return address for a call
			TOS_RETURN_ADDR:   tos_next = instruction_pointer + word_t'(1);
			TOS_BASE_POINTER:  tos_next = base_pointer;
			TOS_PARAM:         tos_next = param;
			TOS_ALU_RESULT:    tos_next = alu_result;
			TOS_MEMORY_RESULT: tos_next = data_mem_read_value;
			default:           tos_next = top_of_stack;
		endcase
	end

	always_comb
	begin
		case (bp_sel)
			BP_ALU:  bp_next = alu_result;
			BP_MEM:  bp_next = data_mem_read_value;
			default: bp_next = base_pointer;
		endcase
	end

	always_comb
	begin
		case (ip_sel)
			IP_NEXT:            ip_next = instruction_pointer + word_t'(1);
			IP_BRANCH_TARGET:   ip_next = param;
			IP_MEM_READ_RESULT: ip_next = data_mem_read_value;
			IP_STACK_TARGET:    ip_next = top_of_stack;
			default:            ip_next = instruction_pointer;
		endcase
	end

	// Fetch address is the next pointer so the instruction arrives with the state change
	assign instr_mem_address = ip_next;

	always_comb
	begin
		case (ma_sel)
			MA_TOP_OF_STACK:            data_mem_address = top_of_stack;
			MA_ALU:                     data_mem_address = alu_result;
			MA_BASE_POINTER:            data_mem_address = base_pointer;
			MA_STACK_POINTER_MINUS_ONE: data_mem_address = stack_pointer - word_t'(1);
			default:                    data_mem_address = stack_pointer;
		endcase
	end

	always_comb
	begin
		case (mw_sel)
			MW_TOP_OF_STACK:    data_mem_write_value = top_of_stack;
			MW_MEM_READ_RESULT: data_mem_write_value = data_mem_read_value;
			default:            data_mem_write_value = base_pointer;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			top_of_stack <= '0;
			stack_pointer <= SP_RESET;
			base_pointer <= BP_RESET;
			// All ones so the first fetch after reset wraps to address 0
			instruction_pointer <= '1;
		end
		else
		begin
			top_of_stack <= tos_next;
			stack_pointer <= sp_next;
			base_pointer <= bp_next;
			instruction_pointer <= ip_next;
		end
	end

endmodule

`default_nettype wire

// ==== src/ctrl_pkg.sv ====
// Micro-architecture package: sequencer states and datapath select encodings
`default_nettype none

package ctrl_pkg;

	typedef enum logic [3:0] {
		ST_DECODE,
		ST_GOT_NOS,
		ST_LOAD_TOS1,
		ST_PUSH_MEM_RESULT,
		ST_GETLOCAL2,
		ST_RETURN2,
		ST_RETURN3,
		ST_GOT_STORE_VALUE,
		ST_BFALSE2
	} state_e;

	typedef enum logic [1:0] {
		SP_CURRENT,
		SP_DECREMENT,
		SP_INCREMENT,
		SP_ALU
	} sp_sel_e;

	typedef enum logic [1:0] {
		OP0_TOP_OF_STACK,
		OP0_STACK_POINTER,
		OP0_BASE_POINTER
	} op0_sel_e;

	typedef enum logic [1:0] {
		OP1_MEM_READ,
		OP1_PARAM,
		OP1_ONE
	} op1_sel_e;

	typedef enum logic [2:0] {
		TOS_CURRENT,
		TOS_RETURN_ADDR,
		TOS_BASE_POINTER,
		TOS_PARAM,
		TOS_ALU_RESULT,
		TOS_MEMORY_RESULT
	} tos_sel_e;

	typedef enum logic [2:0] {
		MA_STACK_POINTER,
		MA_TOP_OF_STACK,
		MA_ALU,
		MA_BASE_POINTER,
		MA_STACK_POINTER_MINUS_ONE
	} ma_sel_e;

	typedef enum logic [1:0] {
		MW_BASE_POINTER,
		MW_TOP_OF_STACK,
		MW_MEM_READ_RESULT
	} mw_sel_e;

	typedef enum logic [1:0] {
		BP_CURRENT,
		BP_ALU,
		BP_MEM
	} bp_sel_e;

	typedef enum logic [2:0] {
		IP_CURRENT,
		IP_NEXT,
		IP_BRANCH_TARGET,
		IP_MEM_READ_RESULT,
		IP_STACK_TARGET
	} ip_sel_e;

endpackage

`default_nettype wire

// ==== src/isa_pkg.sv ====
// Instruction set package: word and instruction types, opcode enumeration, field helpers
`default_nettype none

`include "core_config.svh"

package isa_pkg;

	typedef logic [`CORE_WORD_W-1:0] word_t;
	typedef logic [`CORE_INSTR_W-1:0] instr_t;

	// Gaps in the numbering are unused codes that execute as nop
	typedef enum logic [`CORE_OPCODE_W-1:0] {
		OP_NOP      = 5'd0,
		OP_CALL     = 5'd1,
		OP_RETURN   = 5'd2,
		OP_POP      = 5'd3,
		OP_LOAD     = 5'd4,
		OP_STORE    = 5'd5,
		OP_ADD      = 5'd6,
		OP_SUB      = 5'd7,
		OP_GTR      = 5'd9,
		OP_GTE      = 5'd10,
		OP_EQ       = 5'd11,
		OP_NEQ      = 5'd12,
		OP_DUP      = 5'd13,
		OP_AND      = 5'd16,
		OP_OR       = 5'd17,
		OP_XOR      = 5'd18,
		OP_LSHIFT   = 5'd19,
		OP_RSHIFT   = 5'd20,
		OP_GETBP    = 5'd21,
		OP_RESERVE  = 5'd24,
		OP_PUSH     = 5'd25,
		OP_GOTO     = 5'd26,
		OP_BFALSE   = 5'd27,
		OP_GETLOCAL = 5'd29,
		OP_SETLOCAL = 5'd30,
		OP_CLEANUP  = 5'd31
	} opcode_e;

	// Opcode sits in the upper bits of the instruction
	function automatic opcode_e instr_opcode(instr_t instr);
		return opcode_e'(instr[`CORE_INSTR_W-1 -: `CORE_OPCODE_W]);
	endfunction

	function automatic word_t instr_param(instr_t instr);
		return instr[`CORE_WORD_W-1:0];
	endfunction

	function automatic instr_t make_instr(opcode_e op, word_t param);
		return {op, param};
	endfunction

endpackage

`default_nettype wire

// ==== src/lisp_core.sv ====
// Lisp core top level: connects sequencer, datapath and ALU to the memory ports
`default_nettype none

module lisp_core (
	input  logic            clk,
	input  logic            rst_n,
	output isa_pkg::word_t  instr_mem_address,
	input  isa_pkg::instr_t instr_mem_read_value,
	output isa_pkg::word_t  data_mem_address,
	input  isa_pkg::word_t  data_mem_read_value,
	output isa_pkg::word_t  data_mem_write_value,
	output logic            data_mem_write_enable
);

	import isa_pkg::*;
	import ctrl_pkg::*;

	opcode_e  opcode;
	opcode_e  alu_op;
	word_t    param;
	word_t    top_of_stack;
	word_t    stack_pointer;
	word_t    base_pointer;
	word_t    alu_result;
	sp_sel_e  sp_sel;
	op0_sel_e op0_sel;
	op1_sel_e op1_sel;
	tos_sel_e tos_sel;
	ma_sel_e  ma_sel;
	mw_sel_e  mw_sel;
	bp_sel_e  bp_sel;
	ip_sel_e  ip_sel;

	// Instruction fields
	assign opcode = instr_opcode(instr_mem_read_value);
	assign param = instr_param(instr_mem_read_value);

	core_control control (
		.clk                   (clk),
		.rst_n                 (rst_n),
		.opcode                (opcode),
		.param                 (param),
		.top_of_stack          (top_of_stack),
		.sp_sel                (sp_sel),
		.op0_sel               (op0_sel),
		.op1_sel               (op1_sel),
		.tos_sel               (tos_sel),
		.ma_sel                (ma_sel),
		.mw_sel                (mw_sel),
		.bp_sel                (bp_sel),
		.ip_sel                (ip_sel),
		.alu_op                (alu_op),
		.data_mem_write_enable (data_mem_write_enable)
	);

	core_datapath datapath (
		.clk                  (clk),
		.rst_n                (rst_n),
		.sp_sel               (sp_sel),
		.tos_sel              (tos_sel),
		.ma_sel               (ma_sel),
		.mw_sel               (mw_sel),
		.bp_sel               (bp_sel),
		.ip_sel               (ip_sel),
		.param                (param),
		.alu_result           (alu_result),
		.data_mem_read_value  (data_mem_read_value),
		.top_of_stack         (top_of_stack),
		.stack_pointer        (stack_pointer),
		.base_pointer         (base_pointer),
		.instr_mem_address    (instr_mem_address),
		.data_mem_address     (data_mem_address),
		.data_mem_write_value (data_mem_write_value)
	);

	stack_alu alu (
		.op0_sel             (op0_sel),
		.op1_sel             (op1_sel),
		.alu_op              (alu_op),
		.top_of_stack        (top_of_stack),
		.stack_pointer       (stack_pointer),
		.base_pointer        (base_pointer),
		.param               (param),
		.data_mem_read_value (data_mem_read_value),
		.alu_result          (alu_result)
	);

endmodule

`default_nettype wire

// ==== src/stack_alu.sv ====
// Stack ALU: operand selection and arithmetic, compare, logic and shift operations
`default_nettype none

module stack_alu (
	input  ctrl_pkg::op0_sel_e op0_sel,
	input  ctrl_pkg::op1_sel_e op1_sel,
	input  isa_pkg::opcode_e   alu_op,
	input  isa_pkg::word_t     top_of_stack,
	input  isa_pkg::word_t     stack_pointer,
	input  isa_pkg::word_t     base_pointer,
	input  isa_pkg::word_t     param,
	input  isa_pkg::word_t     data_mem_read_value,
	output isa_pkg::word_t     alu_result
);

	import isa_pkg::*;
	import ctrl_pkg::*;

	word_t op0;
	word_t op1;
	word_t diff;
	logic  zero;
	logic  negative;

	always_comb
	begin
		case (op0_sel)
			OP0_TOP_OF_STACK:  op0 = top_of_stack;
			OP0_STACK_POINTER: op0 = stack_pointer;
			OP0_BASE_POINTER:  op0 = base_pointer;
			default:           op0 = '0;
		endcase
	end

	always_comb
	begin
		case (op1_sel)
			OP1_MEM_READ: op1 = data_mem_read_value;
			OP1_PARAM:    op1 = param;
			OP1_ONE:      op1 = word_t'(1);
			default:      op1 = '0;
		endcase
	end

	// Compares all work from the difference
	assign diff = op0 - op1;
	assign zero = (diff == '0);
	assign negative = diff[$bits(word_t)-1];

	always_comb
	begin
		case (alu_op)
			OP_ADD:    alu_result = op0 + op1;
			OP_SUB:    alu_result = diff;
			OP_GTR:    alu_result = word_t'(!negative && !zero);
			OP_GTE:    alu_result = word_t'(!negative);
			OP_EQ:     alu_result = word_t'(zero);
			OP_NEQ:    alu_result = word_t'(!zero);
			OP_AND:    alu_result = op0 & op1;
			OP_OR:     alu_result = op0 | op1;
			OP_XOR:    alu_result = op0 ^ op1;
			OP_LSHIFT: alu_result = op0 << op1;
			OP_RSHIFT: alu_result = op0 >> op1;
			default:   alu_result = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== verif/core_tb.sv ====
// Core testbench: clock, reset, program builder, directed tests, timeout and report
`default_nettype none

`include "core_config.svh"

module core_tb;

	import isa_pkg::*;

	// About three cycles per instruction over all tests plus resets, doubled
	localparam int CYCLE_LIMIT = 5000;
	localparam word_t BP_RESET = word_t'(`CORE_DMEM_SIZE - 4);

	logic   clk;
	logic   rst_n;
	word_t  instr_mem_address;
	instr_t instr_mem_read_value;
	word_t  data_mem_address;
	word_t  data_mem_read_value;
	word_t  data_mem_write_value;
	logic   data_mem_write_enable;

	int          errors = 0;
	int          checks = 0;
	int          cycle_count = 0;
	int          pc = 0;
	word_t       halt_addr = '0;
	logic [31:0] rng_state = 32'd85;

	lisp_core UUT (
		.clk                   (clk),
		.rst_n                 (rst_n),
		.instr_mem_address     (instr_mem_address),
		.instr_mem_read_value  (instr_mem_read_value),
		.data_mem_address      (data_mem_address),
		.data_mem_read_value   (data_mem_read_value),
		.data_mem_write_value  (data_mem_write_value),
		.data_mem_write_enable (data_mem_write_enable)
	);

	tb_mem_model mem (
		.clk               (clk),
		.instr_address     (instr_mem_address),
		.instr_read_value  (instr_mem_read_value),
		.data_address      (data_mem_address),
		.data_read_value   (data_mem_read_value),
		.data_write_value  (data_mem_write_value),
		.data_write_enable (data_mem_write_enable)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT)
		begin
			$display("Error: simulation timed out after %0d cycles", cycle_count);
			$display("Regression failed");
			$finish;
		end
	end

	function automatic word_t next_random();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state[15:0];
	endfunction

	// Expected result with x on top of the stack and y below it
	function automatic word_t expected_result(opcode_e op, word_t x, word_t y);
		word_t d;
		d = x - y;
		case (op)
			OP_ADD:    return x + y;
			OP_SUB:    return d;
			OP_GTR:    return word_t'(!d[15] && d != 0);
			OP_GTE:    return word_t'(!d[15]);
			OP_EQ:     return word_t'(d == 0);
			OP_NEQ:    return word_t'(d != 0);
			OP_AND:    return x & y;
			OP_OR:     return x | y;
			OP_XOR:    return x ^ y;
			OP_LSHIFT: return x << y;
			OP_RSHIFT: return x >> y;
			default:   return '0;
		endcase
	endfunction

	task automatic emit(opcode_e op, word_t p);
		mem.rom[pc] = make_instr(op, p);
		pc = pc + 1;
	endtask

	// Jump to self marks the end of a program
	task automatic emit_halt();
		halt_addr = word_t'(pc);
		emit(OP_GOTO, halt_addr);
	endtask

	task automatic check_value(string name, word_t expected, word_t actual);
		checks = checks + 1;
		assert (actual == expected)
		else
		begin
			errors = errors + 1;
			$display("Fail %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic check_word(string name, word_t addr, word_t expected);
		check_value(name, expected, mem.ram[addr]);
	endtask

	// Assert reset and clear both memories so a new program can be loaded
	task automatic begin_test();
		int i;
		@(posedge clk);
		rst_n <= 1'b0;
		for (i = 0; i < 65536; i = i + 1)
			mem.rom[i] = '0;
		for (i = 0; i < `CORE_DMEM_SIZE; i = i + 1)
			mem.ram[i] = '0;
		pc = 0;
	endtask

	task automatic release_reset();
		repeat (8)
		begin
			@(negedge clk);
			checks = checks + 1;
			assert (data_mem_write_enable == 1'b0)
			else
			begin
				errors = errors + 1;
				$display("Error: data memory write enable was high during reset");
			end
		end
		@(posedge clk);
		rst_n <= 1'b1;
	endtask

	task automatic wait_halt();
		int stable;
		stable = 0;
		while (stable < 4)
		begin
			@(negedge clk);
			if (instr_mem_address == halt_addr)
				stable = stable + 1;
			else
				stable = 0;
		end
	endtask

	task automatic test_reset();
		begin_test();
		emit(OP_NOP, '0);
		emit_halt();
		release_reset();
		@(negedge clk);
		check_value("reset first fetch", 16'h0000, instr_mem_address);
		@(negedge clk);
		check_value("reset second fetch", 16'h0001, instr_mem_address);
		wait_halt();
	endtask

	task automatic test_binary();
		opcode_e ops[11];
		word_t   exp_q[$];
		word_t   addr_q[$];
		string   name_q[$];
		word_t   a;
		word_t   b;
		word_t   y;
		word_t   addr;
		int      pair;
		int      k;
		ops = '{OP_ADD, OP_SUB, OP_GTR, OP_GTE, OP_EQ, OP_NEQ,
			OP_AND, OP_OR, OP_XOR, OP_LSHIFT, OP_RSHIFT};
		begin_test();
		for (pair = 0; pair < 8; pair = pair + 1)
		begin
			a = next_random();
			b = next_random();
			// Last pair has equal operands so the compares also see a zero difference
			if (pair == 7)
				b = a;
			for (k = 0; k < 11; k = k + 1)
			begin
				// Keep shift amounts inside the word
				y = (ops[k] == OP_LSHIFT || ops[k] == OP_RSHIFT) ? (a & 16'h000f) : a;
				addr = word_t'(16'h0100 + pair * 16 + k);
				emit(OP_PUSH, y);
				emit(OP_PUSH, b);
				emit(ops[k], '0);
				emit(OP_PUSH, addr);
				emit(OP_STORE, '0);
				exp_q.push_back(expected_result(ops[k], b, y));
				addr_q.push_back(addr);
				name_q.push_back($sformatf("binary %s pair %0d", ops[k].name(), pair));
			end
		end
		emit_halt();
		release_reset();
		wait_halt();
		for (k = 0; k < exp_q.size(); k = k + 1)
			check_word(name_q[k], addr_q[k], exp_q[k]);
	endtask

	task automatic test_stack();
		word_t v1;
		word_t v2;
		word_t v3;
		word_t w;
		word_t p;
		v1 = next_random();
		v2 = next_random();
		v3 = next_random();
		w = next_random();
		p = next_random();
		begin_test();
		mem.ram[16'h0030] = w;
		emit(OP_PUSH, v1);
		emit(OP_DUP, '0);
		emit(OP_PUSH, 16'h0020);
		emit(OP_STORE, '0);
		emit(OP_POP, '0);
		emit(OP_PUSH, 16'h0021);
		emit(OP_STORE, '0);
		emit(OP_PUSH, v2);
		emit(OP_PUSH, p);
		emit(OP_POP, '0);
		emit(OP_PUSH, 16'h0022);
		emit(OP_STORE, '0);
		emit(OP_PUSH, 16'h0030);
		emit(OP_LOAD, '0);
		emit(OP_PUSH, 16'h0023);
		emit(OP_STORE, '0);
		emit(OP_PUSH, v3);
		emit(OP_PUSH, 16'h0024);
		emit(OP_STORE, '0);
		emit(OP_PUSH, 16'h0024);
		emit(OP_LOAD, '0);
		emit(OP_PUSH, 16'h0025);
		emit(OP_STORE, '0);
		emit_halt();
		release_reset();
		wait_halt();
		check_word("dup first store", 16'h0020, v1);
		check_word("dup second store", 16'h0021, v1);
		check_word("pop", 16'h0022, v2);
		check_word("load preloaded", 16'h0023, w);
		check_word("store", 16'h0024, v3);
		check_word("store then load", 16'h0025, v3);
	endtask

	task automatic test_bfalse(word_t cond, string name);
		begin_test();
		emit(OP_PUSH, cond);
		emit(OP_BFALSE, 16'd6);
		emit(OP_PUSH, 16'hfa11);
		emit(OP_PUSH, 16'h0040);
		emit(OP_STORE, '0);
		emit(OP_GOTO, 16'd9);
		emit(OP_PUSH, 16'h7a7e);
		emit(OP_PUSH, 16'h0041);
		emit(OP_STORE, '0);
		emit_halt();
		release_reset();
		wait_halt();
		check_word({name, " fall through"}, 16'h0040, (cond == 0) ? 16'h0000 : 16'hfa11);
		check_word({name, " taken"}, 16'h0041, (cond == 0) ? 16'h7a7e : 16'h0000);
	endtask

	task automatic test_goto();
		begin_test();
		emit(OP_GOTO, 16'd4);
		emit(OP_PUSH, 16'hdead);
		emit(OP_PUSH, 16'h0050);
		emit(OP_STORE, '0);
		emit(OP_PUSH, 16'hc0de);
		emit(OP_PUSH, 16'h0051);
		emit(OP_STORE, '0);
		emit_halt();
		release_reset();
		wait_halt();
		check_word("goto skipped", 16'h0050, 16'h0000);
		check_word("goto target", 16'h0051, 16'hc0de);
	endtask

	task automatic test_call();
		word_t arg;
		word_t k;
		arg = next_random() & 16'h0fff;
		k = 16'h0123;
		begin_test();
		emit(OP_GETBP, '0);
		emit(OP_PUSH, 16'h0060);
		emit(OP_STORE, '0);
		emit(OP_PUSH, arg);
		emit(OP_PUSH, 16'd10);
		emit(OP_CALL, '0);
		emit(OP_CLEANUP, 16'd1);
		emit(OP_PUSH, 16'h0061);
		emit(OP_STORE, '0);
		emit_halt();
		// Callee starts at address 10 and finds its argument at base pointer plus one
		emit(OP_RESERVE, 16'd1);
		emit(OP_GETLOCAL, 16'd1);
		emit(OP_PUSH, k);
		emit(OP_ADD, '0);
		emit(OP_SETLOCAL, 16'd1);
		emit(OP_GETLOCAL, 16'd1);
		emit(OP_RETURN, '0);
		release_reset();
		wait_halt();
		check_word("getbp before call", 16'h0060, BP_RESET);
		check_word("call result", 16'h0061, arg + k);
	endtask

	initial
	begin
		rst_n = 1'b0;
		test_reset();
		test_binary();
		test_stack();
		test_bfalse(16'h0000, "bfalse zero");
		test_bfalse(16'h0001 | next_random(), "bfalse nonzero");
		test_goto();
		test_call();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verif/tb_mem_model.sv ====
// Testbench memories: instruction ROM and data RAM, both with synchronous read
`default_nettype none

`include "core_config.svh"

module tb_mem_model (
	input  logic            clk,
	input  isa_pkg::word_t  instr_address,
	output isa_pkg::instr_t instr_read_value,
	input  isa_pkg::word_t  data_address,
	output isa_pkg::word_t  data_read_value,
	input  isa_pkg::word_t  data_write_value,
	input  logic            data_write_enable
);

	import isa_pkg::*;

	localparam int DMEM_ADDR_W = $clog2(`CORE_DMEM_SIZE);

	// Full 16-bit instruction space, cleared and loaded by the test tasks
	instr_t rom [0:65535];
	word_t  ram [0:`CORE_DMEM_SIZE-1];

	initial
	begin
		instr_read_value = '0;
		data_read_value = '0;
	end

	always @(posedge clk)
	begin
		instr_read_value <= rom[instr_address];
	end

	// Read returns the old word when the same address is written at this edge
	always @(posedge clk)
	begin
		data_read_value <= ram[data_address[DMEM_ADDR_W-1:0]];
		if (data_write_enable)
			ram[data_address[DMEM_ADDR_W-1:0]] <= data_write_value;
	end

endmodule

`default_nettype wire
